// ==== filelist.f ====
hw/cache_pkg.sv
hw/sync_ram.sv
hw/cache_arrays.sv
hw/cache_ctrl.sv
hw/mem_burst.sv
hw/cache_top.sv
tests/main_mem_model.sv
tests/tb_cache.sv

// ==== hw/cache_arrays.sv ====
// ############################
// flag and data storage of both ways, hit check and way merge
// ############################

`timescale 1ns/10ps

module cache_arrays (
	input  logic                  clk,
	input  cache_pkg::index_t     index,
	input  logic                  rd,
	input  logic                  wr,
	input  cache_pkg::tag_t       tag_in,
	input  cache_pkg::way_sel_t   way_sel,
	input  cache_pkg::word_sel_t  word_sel,
	input  cache_pkg::data_t      wdata_word,
	input  cache_pkg::block_t     refill_block,
	input  logic                  fill,
	input  cache_pkg::flag_line_t flag_line_in,
	output logic                  hit0,
	output logic                  hit1,
	output logic                  dirty0,
	output logic                  dirty1,
	output logic                  lru,
	output cache_pkg::tag_t       victim_tag,
	output cache_pkg::data_t      rdata_word,
	output cache_pkg::block_t     victim_block
);

	import cache_pkg::*;

	flag_line_t flag_q, flag_wr;
	data_line_t data_q, data_wr;
	logic       sel_w1;
	logic [1:0] way_en;	// ways touched by a write

	sync_ram #(.line_t(flag_line_t)) flag_ram (
		.clk   (clk),
		.addr  (index),
		.rd    (rd),
		.wr    (wr),
		.wdata (flag_wr),
		.q     (flag_q)
	);

	sync_ram #(.line_t(data_line_t)) data_ram (
		.clk   (clk),
		.addr  (index),
		.rd    (rd),
		.wr    (wr),
		.wdata (data_wr),
		.q     (data_q)
	);

	assign hit0   = flag_q.w0.valid && (flag_q.w0.tag == tag_in);
	assign hit1   = flag_q.w1.valid && (flag_q.w1.tag == tag_in);
	assign dirty0 = flag_q.w0.valid && flag_q.w0.dirty;	// only a valid way can be dirty
	assign dirty1 = flag_q.w1.valid && flag_q.w1.dirty;
	assign lru    = flag_q.lru;

	// read side follows the selected way
	assign sel_w1       = (way_sel == way_sel_w1);
	assign victim_tag   = sel_w1 ? flag_q.w1.tag : flag_q.w0.tag;
	assign victim_block = data_q[sel_w1];
	assign rdata_word   = victim_block[word_sel];

	assign way_en[0] = (way_sel == way_sel_w0) || (way_sel == way_sel_all);
	assign way_en[1] = (way_sel == way_sel_w1) || (way_sel == way_sel_all);

	always_comb begin
		data_wr = data_q;	// start from the last read line
		for (int w = 0; w < 2; w++) begin
			if (way_en[w]) begin
				if (fill)
					data_wr[w] = refill_block;
				else
					data_wr[w][word_sel] = wdata_word;
			end
		end
		// lru always from the controller, other way's flags kept
		flag_wr       = flag_line_in;
		flag_wr.spare = '0;
		if (!way_en[0])
			flag_wr.w0 = flag_q.w0;
		if (!way_en[1])
			flag_wr.w1 = flag_q.w1;
	end

endmodule : cache_arrays

// ==== hw/cache_ctrl.sv ====
// ############################
// request register and miss FSM, lookup / write back / refill / access
// ############################

`timescale 1ns/10ps

module cache_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	// processor side
	input  logic                  req,
	input  logic                  we,
	input  cache_pkg::addr_t      addr,
	input  cache_pkg::data_t      wdata,
	output cache_pkg::data_t      rdata,
	output logic                  hit,
	output logic                  done,
	output logic                  ready,
	// arrays
	output cache_pkg::index_t     index,
	output logic                  rd,
	output logic                  wr,
	output cache_pkg::tag_t       tag_in,
	output cache_pkg::way_sel_t   way_sel,
	output cache_pkg::word_sel_t  word_sel,
	output cache_pkg::data_t      wdata_word,
	output cache_pkg::block_t     refill_block,
	output logic                  fill,
	output cache_pkg::flag_line_t flag_line_in,
	input  logic                  hit0,
	input  logic                  hit1,
	input  logic                  dirty0,
	input  logic                  dirty1,
	input  logic                  lru,
	input  cache_pkg::tag_t       victim_tag,
	input  cache_pkg::data_t      rdata_word,
	input  cache_pkg::block_t     victim_block,
	// burst engine
	output logic                  burst_start,
	output logic                  burst_write,
	output cache_pkg::addr_t      burst_addr,
	output cache_pkg::block_t     burst_wdata,
	input  cache_pkg::block_t     burst_rdata,
	input  logic                  burst_done
);

	import cache_pkg::*;

	typedef enum logic [2:0] {
		clear, idle, check_0, check_1,
		write_back, refill, refill_write, finish
	} state_t;

	state_t    state;
	index_t    clear_cnt;	// reset sweep pointer
	logic      missed;	// lookup outcome, repeated at done
	addr_t     addr_q;
	logic      we_q;
	data_t     wdata_q;
	logic      way_q;	// way in use after check_1
	tag_t      tag_q;
	index_t    index_q;
	word_sel_t word_q;
	logic      accept;
	logic      way_hit;
	logic      target;
	logic      cur_way;
	logic      sel_dirty;
	way_flag_t new_flag;

	// address split
	assign tag_q   = addr_q[addr_w-1 -: tag_w];
	assign index_q = addr_q[offset_w +: index_w];
	assign word_q  = addr_q[offset_w-1 -: $bits(word_sel_t)];

	assign accept  = req && ready;
	assign way_hit = hit0 || hit1;
	// no invalidation here, so lru reaches an empty way while one is left
	assign target    = hit0 ? 1'b0 : (hit1 ? 1'b1 : lru);
	assign cur_way   = (state == check_1) ? target : way_q;
	assign sel_dirty = cur_way ? dirty1 : dirty0;

	// processor side
	assign ready = (state == idle) || (state == finish);	// next req may overlap done
	assign done  = (state == finish);
	assign hit   = done && !missed;
	assign rdata = rdata_word;	// read before the finish write lands

	// arrays side
	assign index        = (state == clear) ? clear_cnt : index_q;
	assign rd           = (state == check_0);
	assign wr           = (state == clear) || (state == refill_write) || (state == finish);
	assign tag_in       = tag_q;
	assign word_sel     = word_q;
	assign wdata_word   = we_q ? wdata_q : rdata_word;	// read rewrites the same word
	assign refill_block = burst_rdata;
	assign fill         = (state == refill_write);

	always_comb begin
		case (state)
			clear:                 way_sel = way_sel_all;
			idle, check_0:         way_sel = way_sel_none;
			default:               way_sel = cur_way ? way_sel_w1 : way_sel_w0;
		endcase
	end

	// fresh block is clean, dirty only set on the final access
	assign new_flag = '{valid: 1'b1,
		dirty: (state == finish) && (we_q || sel_dirty),
		tag: tag_q};

	always_comb begin
		flag_line_in       = '0;	// sweep writes all invalid
		if (state != clear) begin
			flag_line_in.lru = ~cur_way;	// point away from the way just used
			flag_line_in.w0  = new_flag;
			flag_line_in.w1  = new_flag;	// arrays keep only the selected one
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= clear;
			clear_cnt   <= '0;
			missed      <= 1'b0;
			burst_start <= 1'b0;
		end else begin
			burst_start <= 1'b0;
			case (state)
				clear: begin
					clear_cnt <= clear_cnt + 1'b1;
					if (clear_cnt == index_t'(num_sets - 1))
						state <= idle;
				end
				idle: begin
					if (accept) begin
						missed <= 1'b0;
						state  <= check_0;
					end
				end
				check_0: state <= check_1;	// flag and data read issued
				check_1: begin
					if (way_hit) begin
						state <= finish;
					end else begin
						missed      <= 1'b1;
						burst_start <= 1'b1;
						state       <= sel_dirty ? write_back : refill;
					end
				end
				write_back: begin
					if (burst_done) begin
						burst_start <= 1'b1;	// chain the refill
						state       <= refill;
					end
				end
				refill: if (burst_done) state <= refill_write;
				refill_write: state <= check_0;	// redo lookup, now a hit
				finish: begin
					if (accept) begin
						missed <= 1'b0;
						state  <= check_0;
					end else begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// request and burst payload
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= addr;
			we_q    <= we;
			wdata_q <= wdata;
		end
		if (state == check_1)
			way_q <= target;
		if (state == check_1 && !way_hit) begin
			burst_write <= sel_dirty;
			burst_addr  <= sel_dirty ? {victim_tag, index_q, {offset_w{1'b0}}}
				: {tag_q, index_q, {offset_w{1'b0}}};
			burst_wdata <= victim_block;
		end
		if (state == write_back && burst_done) begin
			burst_write <= 1'b0;
			burst_addr  <= {tag_q, index_q, {offset_w{1'b0}}};
		end
	end

endmodule : cache_ctrl

// ==== hw/cache_pkg.sv ====
// ############################
// cache geometry, line layouts and way select codes
// ############################

package cache_pkg;

	localparam int addr_w          = 32;	// processor byte address
	localparam int word_w          = 32;
	localparam int words_per_block = 4;
	localparam int index_w         = 9;	// 512 sets
	localparam int offset_w        = 4;	// byte offset in a block
	localparam int tag_w           = addr_w - index_w - offset_w;
	localparam int num_sets        = 1 << index_w;

	typedef logic [addr_w-1:0]  addr_t;
	typedef logic [word_w-1:0]  data_t;
	typedef logic [index_w-1:0] index_t;
	typedef logic [tag_w-1:0]   tag_t;

	// one way's block, word 0 in the low bits
	typedef data_t [words_per_block-1:0] block_t;

	// way 1 block on top, way 0 below
	typedef block_t [1:0] data_line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} way_flag_t;	// 21 bits

	typedef struct packed {
		logic      lru;	// way to evict next
		logic [4:0] spare;
		way_flag_t w1;
		way_flag_t w0;
	} flag_line_t;	// 48 bits

	typedef enum logic [1:0] {
		way_sel_none,
		way_sel_w0,
		way_sel_w1,
		way_sel_all
	} way_sel_t;

	typedef logic [1:0] word_sel_t;	// word within a block

endpackage : cache_pkg

// ==== hw/cache_top.sv ====
// ############################
// cache top, joins controller, storage and memory burst engine
// ############################

`timescale 1ns/10ps

module cache_top (
	input  logic             clk,
	input  logic             reset,
	// processor port
	input  logic             req,
	input  logic             we,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::data_t wdata,
	output cache_pkg::data_t rdata,
	output logic             hit,
	output logic             done,
	output logic             ready,
	// memory port
	output logic             mem_rd,
	output logic             mem_wr,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::data_t mem_wdata,
	input  cache_pkg::data_t mem_rdata,
	input  logic             mem_ack
);

	import cache_pkg::*;

	// controller to arrays
	index_t     index;
	logic       rd, wr, fill;
	tag_t       tag_in, victim_tag;
	way_sel_t   way_sel;
	word_sel_t  word_sel;
	data_t      wdata_word, rdata_word;
	block_t     refill_block, victim_block;
	flag_line_t flag_line_in;
	logic       hit0, hit1, dirty0, dirty1, lru;
	// controller to burst engine
	logic       burst_start, burst_write, burst_done;
	addr_t      burst_addr;
	block_t     burst_wdata, burst_rdata;

	cache_ctrl ctrl (
		.clk, .reset,
		.req, .we, .addr, .wdata, .rdata, .hit, .done, .ready,
		.index, .rd, .wr, .tag_in, .way_sel, .word_sel, .wdata_word,
		.refill_block, .fill, .flag_line_in,
		.hit0, .hit1, .dirty0, .dirty1, .lru, .victim_tag, .rdata_word, .victim_block,
		.burst_start, .burst_write, .burst_addr, .burst_wdata, .burst_rdata, .burst_done
	);

	cache_arrays arrays (
		.clk,
		.index, .rd, .wr, .tag_in, .way_sel, .word_sel, .wdata_word,
		.refill_block, .fill, .flag_line_in,
		.hit0, .hit1, .dirty0, .dirty1, .lru, .victim_tag, .rdata_word, .victim_block
	);

	mem_burst burst_eng (
		.clk, .reset,
		.burst_start, .burst_write, .burst_addr, .burst_wdata, .burst_rdata, .burst_done,
		.mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
	);

endmodule : cache_top

// ==== hw/mem_burst.sv ====
// ############################
// moves one block to or from memory as four word beats paced by mem_ack
// ############################

`timescale 1ns/10ps

module mem_burst (
	input  logic              clk,
	input  logic              reset,
	// controller side
	input  logic              burst_start,
	input  logic              burst_write,
	input  cache_pkg::addr_t  burst_addr,
	input  cache_pkg::block_t burst_wdata,
	output cache_pkg::block_t burst_rdata,
	output logic              burst_done,
	// memory side
	output logic              mem_rd,
	output logic              mem_wr,
	output cache_pkg::addr_t  mem_addr,
	output cache_pkg::data_t  mem_wdata,
	input  cache_pkg::data_t  mem_rdata,
	input  logic              mem_ack
);

	import cache_pkg::*;

	word_sel_t beat;	// beats acked so far
	logic      active;
	logic      beat_ack;
	logic      last_beat;
	block_t    shift;

	assign active    = mem_rd || mem_wr;
	assign beat_ack  = active && mem_ack;
	assign last_beat = (beat == word_sel_t'(words_per_block - 1));

	// word 0 goes out first
	assign mem_wdata   = shift[0];
	assign burst_rdata = shift;	// read beats end up in place after the last shift

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_rd     <= 1'b0;
			mem_wr     <= 1'b0;
			beat       <= '0;
			burst_done <= 1'b0;
		end else begin
			burst_done <= 1'b0;
			if (burst_start) begin
				mem_rd <= !burst_write;
				mem_wr <= burst_write;
				beat   <= '0;
			end else if (beat_ack) begin
				beat <= beat + 1'b1;
				if (last_beat) begin
					mem_rd     <= 1'b0;	// drop the level with the fourth ack
					mem_wr     <= 1'b0;
					burst_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (burst_start) begin
			shift    <= burst_wdata;
			mem_addr <= burst_addr;	// block base
		end else if (beat_ack) begin
			// read word shifts in at the top as the sent word drops off the bottom
			shift    <= {mem_rdata, shift[words_per_block-1:1]};
			mem_addr <= mem_addr + addr_t'(word_w / 8);
		end
	end

endmodule : mem_burst

// ==== hw/sync_ram.sv ====
// ############################
// one set per entry, read data one clock later
// ############################

`timescale 1ns/10ps

module sync_ram #(
	parameter type line_t = logic [7:0]	// payload per set
) (
	input  logic              clk,
	input  cache_pkg::index_t addr,
	input  logic              rd,
	input  logic              wr,
	input  line_t             wdata,
	output line_t             q
);

	import cache_pkg::*;

	line_t mem [num_sets];

	always_ff @(posedge clk) begin
		if (wr)
			mem[addr] <= wdata;	// whole line at once
		if (rd)
			q <= mem[addr];	// old data on a same-cycle write
		// q keeps the last read while rd is low
	end

endmodule : sync_ram

// ==== run_sim.sh ====
#!/bin/sh
# build the cache testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing -f filelist.f --top-module tb_cache -Mdir "$build_dir" -o tb_cache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/tb_cache" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST PASSED$" "$log"; then
	exit 0
fi
exit 1

// ==== tests/cache_golden.txt ====
# name op(R/W) addr wdata exp_rdata(reads only) exp_hit
cold_read_miss   R 00000100 00000000 5a5a0100 0
read_same_block  R 00000108 00000000 5a5a0108 1
write_hit        W 00000104 cafe0001 00000000 1
read_after_write R 00000104 00000000 cafe0001 1
fill_way1        R 00002100 00000000 5a5a2100 0
evict_dirty      R 00004100 00000000 5a5a4100 0
reread_written   R 00000104 00000000 cafe0001 0
lru_load_a       R 00000200 00000000 5a5a0200 0
lru_load_b       R 00002200 00000000 5a5a2200 0
lru_touch_a      R 00000200 00000000 5a5a0200 1
lru_evict_b      R 00004200 00000000 5a5a4200 0
lru_read_a       R 00000200 00000000 5a5a0200 1
lru_read_b       R 00002200 00000000 5a5a2200 0
mix_wr_miss0     W 00000300 11110000 00000000 0
mix_wr_hit0      W 0000030c 2222000c 00000000 1
mix_wr_miss1     W 00002304 33332304 00000000 0
mix_wr_evict     W 00004308 44444308 00000000 0
mix_rd_tag0      R 00000300 00000000 11110000 0
mix_rd_tag0_hit  R 0000030c 00000000 2222000c 1
mix_rd_tag1      R 00002304 00000000 33332304 0
mix_rd_tag2      R 00004308 00000000 44444308 0
old_set_way1     R 00000104 00000000 cafe0001 1
old_set_way0     R 00004104 00000000 5a5a4104 1

// ==== tests/main_mem_model.sv ====
// ##############################
// behavioural burst memory for the cache testbench, random ack delay per beat
// ##############################

`timescale 1ns/10ps

module main_mem_model #(
	parameter logic [31:0] seed = 32'h1
) (
	input  logic        clk,
	input  logic        mem_rd,
	input  logic        mem_wr,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	output logic [31:0] mem_rdata,
	output logic        mem_ack
);

	logic [31:0] store [logic [29:0]];	// written words only, keyed by word address
	int          delay_left;
	logic        armed;	// delay drawn for the beat in flight

	// untouched words hold a pattern of their own byte address
	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (store.exists(a[31:2]))
			return store[a[31:2]];
		return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	initial begin
		void'($urandom(seed));	// one seed for the whole run
		mem_ack    = 1'b0;
		mem_rdata  = '0;
		delay_left = 0;
		armed      = 1'b0;
		forever begin
			@(negedge clk);
			mem_ack = 1'b0;	// strobe lasts one cycle
			if (mem_rd || mem_wr) begin
				if (!armed) begin
					delay_left = int'($urandom % 4);	// 0 to 3 wait cycles
					armed      = 1'b1;
				end
				if (delay_left == 0) begin
					if (mem_wr)
						store[mem_addr[31:2]] = mem_wdata;
					else
						mem_rdata = read_word(mem_addr);	// valid in the ack cycle
					mem_ack = 1'b1;
					armed   = 1'b0;
				end else begin
					delay_left = delay_left - 1;
				end
			end
		end
	end

endmodule : main_mem_model

// ==== tests/tb_cache.sv ====
// ##############################
// cache testbench, runs the golden table against cache_top and a memory model
// ##############################

`timescale 1ns/10ps

module tb_cache;

	import cache_pkg::*;

	localparam int max_tests       = 64;
	localparam int cycles_per_test = 300;	// worst miss is well below this
	localparam int sweep_cycles    = 600;	// reset plus the 512-set clear

	logic  clk, reset;
	logic  req, we;
	addr_t addr;
	data_t wdata, rdata;
	logic  hit, done, ready;
	logic  mem_rd, mem_wr, mem_ack;
	addr_t mem_addr;
	data_t mem_wdata, mem_rdata;

	// golden table, one entry per test
	logic [8*24-1:0] t_name [max_tests];
	logic            t_we [max_tests];
	addr_t           t_addr [max_tests];
	data_t           t_wdata [max_tests];
	data_t           t_rdata [max_tests];	// reads only
	logic            t_hit [max_tests];
	int              n_tests;
	logic            golden_ok;
	logic            loaded;
	int              pass_cnt, fail_cnt;

	cache_top UUT (
		.clk, .reset,
		.req, .we, .addr, .wdata, .rdata, .hit, .done, .ready,
		.mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
	);

	main_mem_model #(.seed(32'hd3b2_c60b)) memory (
		.clk, .mem_rd, .mem_wr, .mem_addr, .mem_wdata, .mem_rdata, .mem_ack
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	task automatic load_golden();
		int              fd;
		int              n;
		int              hit_exp;
		string           line;
		logic [8*24-1:0] name;
		logic [7:0]      op;
		logic [31:0]     a, wd, rd_exp;
		n_tests = 0;
		fd = $fopen("tests/cache_golden.txt", "r");
		golden_ok = (fd != 0);
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				n = $sscanf(line, "%s %s %h %h %h %d", name, op, a, wd, rd_exp, hit_exp);
				// comment and blank lines give fewer fields
				if (n == 6 && line[0] != "#" && n_tests < max_tests) begin
					t_name[n_tests]  = name;
					t_we[n_tests]    = (op == "W");
					t_addr[n_tests]  = a;
					t_wdata[n_tests] = wd;
					t_rdata[n_tests] = rd_exp;
					t_hit[n_tests]   = (hit_exp != 0);
					n_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	// one request, wait for done, check rdata, hit and hit latency
	task automatic run_one(input int i);
		int   lat;
		logic ok;
		while (!ready)
			@(negedge clk);
		req   = 1'b1;	// may overlap the previous done
		we    = t_we[i];
		addr  = t_addr[i];
		wdata = t_wdata[i];
		@(negedge clk);
		req = 1'b0;
		lat = 1;
		while (!done) begin
			@(negedge clk);
			lat++;
		end
		ok = 1'b1;
		if (!t_we[i] && rdata !== t_rdata[i]) begin
			$display("[FAIL] %0s rdata expected %h actual %h", t_name[i], t_rdata[i], rdata);
			ok = 1'b0;
		end
		if (hit !== t_hit[i]) begin
			$display("[FAIL] %0s hit expected %0b actual %0b", t_name[i], t_hit[i], hit);
			ok = 1'b0;
		end
		if (t_hit[i] && lat != 3) begin	// hit path is fixed at 3 cycles
			$display("[FAIL] %0s hit latency expected 3 actual %0d", t_name[i], lat);
			ok = 1'b0;
		end
		if (ok) begin
			pass_cnt++;
			$display("[PASS] %0s", t_name[i]);
		end else begin
			fail_cnt++;
		end
	endtask

	initial begin
		reset    = 1'b1;
		req      = 1'b0;
		we       = 1'b0;
		addr     = '0;
		wdata    = '0;
		pass_cnt = 0;
		fail_cnt = 0;
		loaded   = 1'b0;
		load_golden();
		loaded = 1'b1;
		if (!golden_ok || n_tests == 0) begin
			$display("could not read any test from tests/cache_golden.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (2) @(negedge clk);
			reset = 1'b0;	// clear sweep runs before ready rises
			for (int i = 0; i < n_tests; i++)
				run_one(i);
			$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0)
				$display("TEST PASSED");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	// watchdog, budget scales with the table length
	initial begin
		int limit;
		wait (loaded);
		limit = n_tests * cycles_per_test + sweep_cycles;
		repeat (limit) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule : tb_cache
